//--- rtl/router_cfg_pkg.sv
`default_nettype none

package router_cfg_pkg;

    // Router geometry
    localparam int num_ports     = 5;
    localparam int port_idx_w    = $clog2(num_ports);

    // Per-input buffer, also the credit budget of every output link
    localparam int buffer_depth  = 4;
    localparam int buf_ptr_w     = $clog2(buffer_depth);
    localparam int credit_w      = $clog2(buffer_depth + 1);

    // Flit fields
    localparam int flit_data_w   = 32;
    localparam int dest_w        = 3;
    localparam int num_endpoints = 2 ** dest_w;

    // Endpoint to output port, highest endpoint first
    localparam logic [num_endpoints-1:0][port_idx_w-1:0] route_table = {
        3'd3,   // Endpoint 7
        3'd2,   // Endpoint 6
        3'd1,   // Endpoint 5
        3'd4,
        3'd3,
        3'd2,
        3'd1,
        3'd0
    };

endpackage : router_cfg_pkg

`default_nettype wire

//--- rtl/router_flit_pkg.sv
`default_nettype none

package router_flit_pkg;

    import router_cfg_pkg::*;

    // Output port number
    typedef logic [port_idx_w-1:0] port_idx_t;

    // One bit per port, used for requests, grants and holds
    typedef logic [num_ports-1:0] port_mask_t;

    // Endpoint address, only meaningful on a head flit
    typedef logic [dest_w-1:0] dest_t;

    typedef logic [flit_data_w-1:0] payload_t;

    // Credits of one output, 0 up to buffer_depth
    typedef logic [credit_w-1:0] credit_cnt_t;

    typedef struct packed {
        payload_t payload;
        dest_t    dest;
        logic     is_tail;
    } flit_t;

endpackage : router_flit_pkg

`default_nettype wire

//--- rtl/input_unit.sv
`default_nettype none

module input_unit (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire router_flit_pkg::flit_t     flit_in,
    input  wire                             send_in,
    input  wire                             advance,
    output logic                            credit_out,
    output router_flit_pkg::flit_t          head_flit,
    output logic                            head_valid,
    output router_flit_pkg::port_idx_t      route
);
    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    flit_t                  mem [buffer_depth];
    logic [buf_ptr_w-1:0]   wr_ptr;
    logic [buf_ptr_w-1:0]   rd_ptr;
    credit_cnt_t            fill;
    logic                   rd_en;
    flit_t                  rd_flit;

    // Set while the next flit to leave the buffer starts a packet
    logic                   head_next;
    dest_t                  dest_q;
    dest_t                  cur_dest;

    assign rd_flit = mem[rd_ptr];

    // Read when something is buffered and the route stage can take it
    assign rd_en      = (fill != '0) && (!head_valid || advance);
    assign credit_out = rd_en;

    // Body flits inherit the destination of their head
    assign cur_dest = head_next ? rd_flit.dest : dest_q;

    always_ff @(posedge clk) begin
        if (send_in) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (send_in) begin
                wr_ptr <= (wr_ptr == buf_ptr_w'(buffer_depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == buf_ptr_w'(buffer_depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill <= fill + credit_cnt_t'(send_in) - credit_cnt_t'(rd_en);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_next <= 1'b1;
        end else if (rd_en) begin
            head_next <= rd_flit.is_tail;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            dest_q <= cur_dest;
        end
    end

    // Route stage, refilled in the same cycle it drains
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_valid <= 1'b0;
        end else if (rd_en) begin
            head_valid <= 1'b1;
        end else if (advance) begin
            head_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            head_flit.payload <= rd_flit.payload;
            head_flit.dest    <= cur_dest;
            head_flit.is_tail <= rd_flit.is_tail;
            route             <= route_table[cur_dest];
        end
    end

endmodule : input_unit

`default_nettype wire

//--- rtl/matrix_arbiter.sv
`default_nettype none

module matrix_arbiter (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire router_flit_pkg::port_mask_t request,
    input  wire router_flit_pkg::port_mask_t hold,
    output router_flit_pkg::port_mask_t      grant
);
    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    // prio[i][j] set means input i currently wins over input j
    port_mask_t prio [num_ports];
    port_mask_t hold_q;
    port_mask_t grant_q;
    port_mask_t blocked;
    port_mask_t locked;
    logic       any_locked;

    // An input is blocked by any requester ranked above it
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            blocked[i] = 1'b0;
            for (int j = 0; j < num_ports; j++) begin
                blocked[i] = blocked[i] | (prio[j][i] & request[j]);
            end
        end
    end

    // Hold is sampled one cycle late so the grant stays put through the tail
    assign locked     = hold_q & grant_q;
    assign any_locked = |locked;
    assign grant      = any_locked ? locked : (request & ~blocked);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= '0;
            grant_q <= '0;
        end else begin
            hold_q  <= hold;
            grant_q <= grant;
        end
    end

    // Granted input drops below everyone else
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < num_ports; i++) begin
                for (int j = 0; j < num_ports; j++) begin
                    prio[i][j] <= (i < j);
                end
            end
        end else begin
            for (int i = 0; i < num_ports; i++) begin
                for (int j = 0; j < num_ports; j++) begin
                    if (i != j) begin
                        prio[i][j] <= (prio[i][j] & ~grant[i]) | grant[j];
                    end
                end
            end
        end
    end

endmodule : matrix_arbiter

`default_nettype wire

//--- rtl/switch_allocator.sv
`default_nettype none

module switch_allocator (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              head_valid [router_cfg_pkg::num_ports],
    input  wire router_flit_pkg::port_idx_t  route      [router_cfg_pkg::num_ports],
    input  wire                              head_tail  [router_cfg_pkg::num_ports],
    input  wire router_flit_pkg::port_mask_t out_free,
    output router_flit_pkg::port_mask_t      grant      [router_cfg_pkg::num_ports],
    output logic                             advance    [router_cfg_pkg::num_ports]
);
    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    port_mask_t request   [num_ports];
    port_mask_t hold      [num_ports];
    port_mask_t arb_grant [num_ports];
    port_mask_t valid_mask;

    // One-hot request per output from each input's route
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            request[o] = '0;
        end
        for (int i = 0; i < num_ports; i++) begin
            valid_mask[i]        = head_valid[i];
            request[route[i]][i] = head_valid[i];
        end
    end

    // Hold drops only in the cycle the tail flit leaves
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                hold[o][i] = ~(head_tail[i] & out_free[o]);
            end
        end
    end

    for (genvar o = 0; o < num_ports; o++) begin : g_arb
        matrix_arbiter u_arb (
            .clk     (clk),
            .rst_n   (rst_n),
            .request (request[o]),
            .hold    (hold[o]),
            .grant   (arb_grant[o])
        );
    end

    // A held grant may sit on an empty route stage
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            grant[o] = arb_grant[o] & valid_mask;
        end
    end

    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            advance[i] = 1'b0;
            for (int o = 0; o < num_ports; o++) begin
                advance[i] = advance[i] | (grant[o][i] & out_free[o]);
            end
        end
    end

endmodule : switch_allocator

`default_nettype wire

//--- rtl/output_stage.sv
`default_nettype none

module output_stage (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire router_flit_pkg::flit_t      head_flit [router_cfg_pkg::num_ports],
    input  wire router_flit_pkg::port_mask_t grant     [router_cfg_pkg::num_ports],
    input  wire                              credit_in [router_cfg_pkg::num_ports],
    output router_flit_pkg::flit_t           flit_out  [router_cfg_pkg::num_ports],
    output logic                             send_out  [router_cfg_pkg::num_ports],
    output router_flit_pkg::port_mask_t      out_free
);
    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    credit_cnt_t credit_cnt [num_ports];

    // One-hot OR crossbar, at most one grant bit per output
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            flit_out[o] = '0;
            for (int i = 0; i < num_ports; i++) begin
                if (grant[o][i]) begin
                    flit_out[o] = flit_out[o] | head_flit[i];
                end
            end
        end
    end

    // Send only while the downstream buffer has room
    always_comb begin
        for (int o = 0; o < num_ports; o++) begin
            send_out[o] = (grant[o] != '0) && (credit_cnt[o] != '0);
            out_free[o] = send_out[o];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int o = 0; o < num_ports; o++) begin
                credit_cnt[o] <= credit_cnt_t'(buffer_depth);
            end
        end else begin
            for (int o = 0; o < num_ports; o++) begin
                credit_cnt[o] <= credit_cnt[o]
                               + credit_cnt_t'(credit_in[o])
                               - credit_cnt_t'(send_out[o]);
            end
        end
    end

endmodule : output_stage

`default_nettype wire

//--- rtl/noc_router.sv
`default_nettype none

module noc_router (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire router_flit_pkg::flit_t  flit_in    [router_cfg_pkg::num_ports],
    input  wire                          send_in    [router_cfg_pkg::num_ports],
    output logic                         credit_out [router_cfg_pkg::num_ports],
    output router_flit_pkg::flit_t       flit_out   [router_cfg_pkg::num_ports],
    output logic                         send_out   [router_cfg_pkg::num_ports],
    input  wire                          credit_in  [router_cfg_pkg::num_ports]
);
    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    flit_t      head_flit  [num_ports];
    logic       head_valid [num_ports];
    logic       head_tail  [num_ports];
    port_idx_t  route      [num_ports];
    logic       advance    [num_ports];
    port_mask_t grant      [num_ports];
    port_mask_t out_free;

    for (genvar i = 0; i < num_ports; i++) begin : g_in
        input_unit u_in (
            .clk        (clk),
            .rst_n      (rst_n),
            .flit_in    (flit_in[i]),
            .send_in    (send_in[i]),
            .advance    (advance[i]),
            .credit_out (credit_out[i]),
            .head_flit  (head_flit[i]),
            .head_valid (head_valid[i]),
            .route      (route[i])
        );

        assign head_tail[i] = head_flit[i].is_tail;
    end

    switch_allocator u_sa (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_valid (head_valid),
        .route      (route),
        .head_tail  (head_tail),
        .out_free   (out_free),
        .grant      (grant),
        .advance    (advance)
    );

    output_stage u_out (
        .clk        (clk),
        .rst_n      (rst_n),
        .head_flit  (head_flit),
        .grant      (grant),
        .credit_in  (credit_in),
        .flit_out   (flit_out),
        .send_out   (send_out),
        .out_free   (out_free)
    );

endmodule : noc_router

`default_nettype wire

//--- dv/router_model.sv
`default_nettype none

module router_model (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire router_flit_pkg::flit_t      flit_in     [router_cfg_pkg::num_ports],
    input  wire                              send_in     [router_cfg_pkg::num_ports],
    input  wire                              credit_out  [router_cfg_pkg::num_ports],
    input  wire router_flit_pkg::flit_t      flit_out    [router_cfg_pkg::num_ports],
    input  wire                              send_out    [router_cfg_pkg::num_ports],
    input  wire                              credit_in   [router_cfg_pkg::num_ports],
    input  wire                              stage_valid [router_cfg_pkg::num_ports],
    input  wire router_flit_pkg::port_idx_t  stage_route [router_cfg_pkg::num_ports],
    output logic                             error_seen,
    output int                               flits_pending
);
    timeunit 1ns;
    timeprecision 1ps;

    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    // Expected flits of each output, one queue per source input
    flit_t exp_q [num_ports][num_ports][$];
    dest_t head_dest [num_ports];
    logic  at_head   [num_ports];
    logic  mid_pkt   [num_ports];
    int    cur_src   [num_ports];
    int    accepted  [num_ports];
    int    returned  [num_ports];
    int    in_flight [num_ports];
    // Other packets started on an output while an input waits there with a head
    int    passed_by [num_ports][num_ports];
    int    sent_total;

    initial begin
        error_seen    = 1'b0;
        flits_pending = 0;
        sent_total    = 0;
        for (int i = 0; i < num_ports; i++) begin
            at_head[i]   = 1'b1;
            mid_pkt[i]   = 1'b0;
            cur_src[i]   = -1;
            accepted[i]  = 0;
            returned[i]  = 0;
            in_flight[i] = 0;
            head_dest[i] = '0;
            for (int j = 0; j < num_ports; j++) begin
                passed_by[i][j] = 0;
            end
        end
    end

    task automatic report(input string msg);
        $display("%s", msg);
        error_seen = 1'b1;
    endtask

    task automatic check_flit(input int o, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            report($sformatf("mismatch flit_out[%0d]: got %h expected %h", o, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            report($sformatf("mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // Body flits take the destination of their head flit
    task automatic accept_flit(input int i, input flit_t f);
        flit_t     e;
        port_idx_t o;
        if (at_head[i]) begin
            head_dest[i] = f.dest;
        end
        e.payload = f.payload;
        e.dest    = head_dest[i];
        e.is_tail = f.is_tail;
        o = route_table[head_dest[i]];
        exp_q[o][i].push_back(e);
        at_head[i]  = f.is_tail;
        accepted[i] = accepted[i] + 1;
    endtask

    // Source of a head flit comes from the tag in the top payload bits
    task automatic output_flit(input int o);
        flit_t got;
        int    src;
        got = flit_out[o];
        src = (cur_src[o] < 0) ? int'(got.payload[flit_data_w-1 -: 3]) : cur_src[o];
        if (src >= num_ports || exp_q[o][src].size() == 0) begin
            report($sformatf("output %0d sent a flit that no input sent to it", o));
        end else begin
            check_flit(o, got, exp_q[o][src].pop_front());
            cur_src[o]   = got.is_tail ? -1 : src;
            mid_pkt[src] = !got.is_tail;
            sent_total   = sent_total + 1;
        end
    endtask

    task automatic fairness_step();
        logic waiting;
        int   src;
        for (int o = 0; o < num_ports; o++) begin
            src = (send_out[o] && cur_src[o] < 0) ?
                  int'(flit_out[o].payload[flit_data_w-1 -: 3]) : -1;
            for (int i = 0; i < num_ports; i++) begin
                waiting = stage_valid[i] && !mid_pkt[i] && (int'(stage_route[i]) == o);
                if (!waiting || i == src) begin
                    passed_by[o][i] = 0;
                end else if (src >= 0) begin
                    passed_by[o][i] = passed_by[o][i] + 1;
                    if (passed_by[o][i] > num_ports - 1) begin
                        report($sformatf("input %0d was passed over too often on output %0d",
                                         i, o));
                    end
                end
            end
        end
    endtask

    task automatic final_check();
        for (int i = 0; i < num_ports; i++) begin
            check_count($sformatf("credit_out pulses on input %0d", i), returned[i], accepted[i]);
        end
        for (int o = 0; o < num_ports; o++) begin
            for (int i = 0; i < num_ports; i++) begin
                if (exp_q[o][i].size() != 0) begin
                    report($sformatf("flits from input %0d never left on output %0d", i, o));
                end
            end
        end
    endtask

    always @(posedge clk) begin
        int acc_sum;
        if (rst_n) begin
            // Uses the packet state of the cycle just ended, so it runs first
            fairness_step();
            acc_sum = 0;
            for (int i = 0; i < num_ports; i++) begin
                if (send_in[i]) begin
                    accept_flit(i, flit_in[i]);
                end
                returned[i] = returned[i] + int'(credit_out[i]);
                if (accepted[i] - returned[i] > buffer_depth) begin
                    report($sformatf("input %0d got more flits than its buffer holds", i));
                end
                if (returned[i] > accepted[i]) begin
                    report($sformatf("input %0d returned a credit for no flit", i));
                end
                acc_sum = acc_sum + accepted[i];
            end
            for (int o = 0; o < num_ports; o++) begin
                if (send_out[o]) begin
                    output_flit(o);
                end
                in_flight[o] = in_flight[o] + int'(send_out[o]) - int'(credit_in[o]);
                if (in_flight[o] > buffer_depth) begin
                    report($sformatf("output %0d sent without a downstream credit", o));
                end
            end
            flits_pending <= acc_sum - sent_total;
        end
    end

endmodule : router_model

`default_nettype wire

//--- dv/router_tb.sv
`default_nettype none

module router_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import router_cfg_pkg::*;
    import router_flit_pkg::*;

    localparam int pkts_per_input = 40;
    localparam int max_pkt_len    = 4;

    logic      clk;
    logic      rst_n;
    flit_t     flit_in     [num_ports];
    logic      send_in     [num_ports];
    logic      credit_out  [num_ports];
    flit_t     flit_out    [num_ports];
    logic      send_out    [num_ports];
    logic      credit_in   [num_ports];
    logic      stage_valid [num_ports];
    port_idx_t stage_route [num_ports];
    logic      model_error;
    int        flits_pending;

    // Packet lengths are drawn up front so the timeout can be sized from them
    int        pkt_len   [num_ports][pkts_per_input];
    int        pkt_cnt   [num_ports];
    int        flit_cnt  [num_ports];
    int        up_credit [num_ports];
    int        owed      [num_ports];
    int        delay     [num_ports];
    int        stall     [num_ports];
    int        total_flits;
    int        cycle_limit;
    int        cycles;
    logic      traffic_on;

    noc_router DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .flit_in    (flit_in),
        .send_in    (send_in),
        .credit_out (credit_out),
        .flit_out   (flit_out),
        .send_out   (send_out),
        .credit_in  (credit_in)
    );

    // Route stage taps for the fairness check
    for (genvar i = 0; i < num_ports; i++) begin : g_tap
        assign stage_valid[i] = DUT.head_valid[i];
        assign stage_route[i] = DUT.route[i];
    end

    router_model u_model (
        .clk           (clk),
        .rst_n         (rst_n),
        .flit_in       (flit_in),
        .send_in       (send_in),
        .credit_out    (credit_out),
        .flit_out      (flit_out),
        .send_out      (send_out),
        .credit_in     (credit_in),
        .stage_valid   (stage_valid),
        .stage_route   (stage_route),
        .error_seen    (model_error),
        .flits_pending (flits_pending)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Finished with errors");
        $fatal(1);
    endtask

    // Payload top bits tag the source input, packet and flit number
    task automatic build_flit(input int i, output flit_t f);
        logic last;
        last = (flit_cnt[i] == pkt_len[i][pkt_cnt[i]] - 1);
        f.payload = {3'(i), 6'(pkt_cnt[i]), 2'(flit_cnt[i]), 21'($urandom)};
        // Body flits get a random dest that the router has to replace
        f.dest    = dest_t'($urandom_range(num_endpoints - 1));
        f.is_tail = last;
        if (last) begin
            flit_cnt[i] = 0;
            pkt_cnt[i]  = pkt_cnt[i] + 1;
        end else begin
            flit_cnt[i] = flit_cnt[i] + 1;
        end
    endtask

    task automatic drive_senders();
        flit_t f;
        for (int i = 0; i < num_ports; i++) begin
            up_credit[i] = up_credit[i] + int'(credit_out[i]);
            if (traffic_on && pkt_cnt[i] < pkts_per_input && up_credit[i] > 0
                && $urandom_range(3) != 0) begin
                build_flit(i, f);
                flit_in[i]   <= f;
                send_in[i]   <= 1'b1;
                up_credit[i] = up_credit[i] - 1;
            end else begin
                send_in[i] <= 1'b0;
            end
        end
    endtask

    // Downstream side, with random return delay and stretches of no credits
    task automatic return_credits();
        for (int o = 0; o < num_ports; o++) begin
            owed[o] = owed[o] + int'(send_out[o]);
            credit_in[o] <= 1'b0;
            if (stall[o] > 0) begin
                stall[o] = stall[o] - 1;
            end else if ($urandom_range(31) == 0) begin
                stall[o] = 1 + $urandom_range(11);
            end else if (owed[o] > 0) begin
                if (delay[o] == 0) begin
                    credit_in[o] <= 1'b1;
                    owed[o]  = owed[o] - 1;
                    delay[o] = $urandom_range(3);
                end else begin
                    delay[o] = delay[o] - 1;
                end
            end
        end
    endtask

    function automatic logic senders_done();
        logic done;
        done = 1'b1;
        for (int i = 0; i < num_ports; i++) begin
            if (pkt_cnt[i] < pkts_per_input) begin
                done = 1'b0;
            end
        end
        return done;
    endfunction

    always @(posedge clk) begin
        drive_senders();
        return_credits();
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            fail_run("timeout: the router did not deliver all packets in time");
        end
    end

    always @(posedge model_error) begin
        fail_run("the reference model found an error");
    end

    initial begin
        void'($urandom(32'h919));
        rst_n       = 1'b0;
        traffic_on  = 1'b0;
        cycles      = 0;
        cycle_limit = 0;
        total_flits = 0;
        for (int i = 0; i < num_ports; i++) begin
            flit_in[i]   = '0;
            send_in[i]   = 1'b0;
            credit_in[i] = 1'b0;
            pkt_cnt[i]   = 0;
            flit_cnt[i]  = 0;
            up_credit[i] = buffer_depth;
            owed[i]      = 0;
            delay[i]     = 0;
            stall[i]     = 0;
            for (int p = 0; p < pkts_per_input; p++) begin
                pkt_len[i][p] = 1 + $urandom_range(max_pkt_len - 1);
                total_flits   = total_flits + pkt_len[i][p];
            end
        end
        cycle_limit = total_flits * 40 + 200;

        repeat (10) @(posedge clk);
        rst_n      <= 1'b1;
        traffic_on <= 1'b1;

        while (!senders_done()) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
        while (flits_pending != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        u_model.final_check();
        @(posedge clk);

        if (!model_error) begin
            $display("Finished with no errors");
            $finish;
        end else begin
            fail_run("the final check found an error");
        end
    end

endmodule : router_tb

`default_nettype wire

//--- compile.f
rtl/router_cfg_pkg.sv
rtl/router_flit_pkg.sv
rtl/input_unit.sv
rtl/matrix_arbiter.sv
rtl/switch_allocator.sv
rtl/output_stage.sv
rtl/noc_router.sv
dv/router_model.sv
dv/router_tb.sv
